// File: list.f
source/matrix_modular_pkg.sv
source/modular_add_lane.sv
source/matrix_element_feeder.sv
source/matrix_result_collector.sv
source/matrix_modular_adder.sv
test/tb_clock_gen.sv
test/matrix_modular_adder_properties.sv
test/matrix_modular_adder_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the matrix modular adder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module matrix_modular_adder_tb \
  -Mdir obj_dir \
  -f list.f

# Keep running past failed assertions so the testbench reports them
output=$(./obj_dir/Vmatrix_modular_adder_tb +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: source/matrix_element_feeder.sv
//////////////////////////////////////////////////
// Matrix element feeder
// Pairs A and B operands, issues them round robin
//////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_element_feeder (
  input  logic                                           CLK,
  input  logic                                           RST,
  input  logic                                           START,
  input  matrix_modular_pkg::operation_t                 OPERATION,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]       MODULO_IN,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]       DATA_A_IN,
  input  logic                                           DATA_A_IN_ENABLE,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]       DATA_B_IN,
  input  logic                                           DATA_B_IN_ENABLE,
  input  logic                                           matrix_done,
  output logic [matrix_modular_pkg::LANES-1:0]           lane_start,
  output logic [matrix_modular_pkg::DATA_SIZE-1:0]       lane_a,
  output logic [matrix_modular_pkg::DATA_SIZE-1:0]       lane_b,
  output matrix_modular_pkg::operation_t                 lane_op,
  output logic [matrix_modular_pkg::DATA_SIZE-1:0]       lane_modulo
);

  // FSM
  matrix_modular_pkg::feeder_state_t state;

  // Captured operands and their flags
  logic [matrix_modular_pkg::DATA_SIZE-1:0] a_hold;
  logic [matrix_modular_pkg::DATA_SIZE-1:0] b_hold;
  logic                                     a_held;
  logic                                     b_held;

  // Round robin lane pointer
  logic [matrix_modular_pkg::LANE_SEL_SIZE-1:0] lane_ptr;
  logic [matrix_modular_pkg::LANES-1:0]         lane_onehot;

  logic start_accept;
  logic loading;
  logic pair_ready;

  // START only counts when idle
  assign start_accept = (state == matrix_modular_pkg::FEEDER_IDLE) && START;
  assign loading      = (state == matrix_modular_pkg::FEEDER_LOAD);

  // Both halves of the element are in
  assign pair_ready = a_held && b_held;

  always_comb begin
    lane_onehot           = '0;
    lane_onehot[lane_ptr] = 1'b1;
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= matrix_modular_pkg::FEEDER_IDLE;
      lane_op    <= matrix_modular_pkg::OP_ADD;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      lane_ptr   <= '0;
      lane_start <= '0;
    end else begin
      // One cycle pulse on the selected lane
      lane_start <= pair_ready ? lane_onehot : '0;

      case (state)
        matrix_modular_pkg::FEEDER_IDLE: begin
          if (START) begin
            lane_op  <= OPERATION;
            lane_ptr <= '0;
            a_held   <= 1'b0;
            b_held   <= 1'b0;
            state    <= matrix_modular_pkg::FEEDER_LOAD;
          end
        end
        matrix_modular_pkg::FEEDER_LOAD: begin
          if (matrix_done) begin
            // Last element left the collector
            a_held <= 1'b0;
            b_held <= 1'b0;
            state  <= matrix_modular_pkg::FEEDER_IDLE;
          end else begin
            // Issue clears the flags, a new strobe sets them again
            a_held <= (a_held && !pair_ready) || DATA_A_IN_ENABLE;
            b_held <= (b_held && !pair_ready) || DATA_B_IN_ENABLE;
            if (pair_ready) begin
              lane_ptr <= lane_ptr + 1'b1;
            end
          end
        end
        default: begin
          state <= matrix_modular_pkg::FEEDER_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_accept) begin
      lane_modulo <= MODULO_IN;
    end
    if (loading && DATA_A_IN_ENABLE) begin
      a_hold <= DATA_A_IN;
    end
    if (loading && DATA_B_IN_ENABLE) begin
      b_hold <= DATA_B_IN;
    end
    // Shared operand bus, qualified by lane_start
    if (pair_ready) begin
      lane_a <= a_hold;
      lane_b <= b_hold;
    end
  end

endmodule

// File: source/matrix_modular_adder.sv
//////////////////////////////////////////////////
// Streaming matrix modular adder, top level
// DATA_OUT = DATA_A +/- DATA_B mod MODULO, row-major
//////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_modular_adder (
  input  logic                                      CLK,
  input  logic                                      RST,
  input  logic                                      START,
  input  matrix_modular_pkg::operation_t            OPERATION,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]  MODULO_IN,
  input  logic [matrix_modular_pkg::INDEX_SIZE-1:0] SIZE_I_IN,
  input  logic [matrix_modular_pkg::INDEX_SIZE-1:0] SIZE_J_IN,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]  DATA_A_IN,
  input  logic                                      DATA_A_IN_ENABLE,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]  DATA_B_IN,
  input  logic                                      DATA_B_IN_ENABLE,
  output logic [matrix_modular_pkg::DATA_SIZE-1:0]  DATA_OUT,
  output logic                                      DATA_OUT_J_ENABLE,
  output logic                                      DATA_OUT_I_ENABLE,
  output logic                                      READY
);

  // Feeder to lanes
  logic [matrix_modular_pkg::LANES-1:0]     lane_start;
  logic [matrix_modular_pkg::DATA_SIZE-1:0] lane_a;
  logic [matrix_modular_pkg::DATA_SIZE-1:0] lane_b;
  matrix_modular_pkg::operation_t           lane_op;
  logic [matrix_modular_pkg::DATA_SIZE-1:0] lane_modulo;

  // Lanes to collector
  logic [matrix_modular_pkg::LANES-1:0]     lane_valid;
  logic [matrix_modular_pkg::DATA_SIZE-1:0] lane_result [matrix_modular_pkg::LANES];

  // Collector to feeder
  logic matrix_done;

  // Operand pairing and issue
  matrix_element_feeder u_feeder (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .OPERATION        (OPERATION),
    .MODULO_IN        (MODULO_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .matrix_done      (matrix_done),
    .lane_start       (lane_start),
    .lane_a           (lane_a),
    .lane_b           (lane_b),
    .lane_op          (lane_op),
    .lane_modulo      (lane_modulo)
  );

  // Identical lanes on the shared operand bus
  for (genvar k = 0; k < matrix_modular_pkg::LANES; k++) begin : g_lane
    modular_add_lane u_lane (
      .CLK    (CLK),
      .RST    (RST),
      .start  (lane_start[k]),
      .a      (lane_a),
      .b      (lane_b),
      .op     (lane_op),
      .modulo (lane_modulo),
      .valid  (lane_valid[k]),
      .result (lane_result[k])
    );
  end

  // In-order drain and output strobes
  matrix_result_collector u_collector (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .SIZE_I_IN         (SIZE_I_IN),
    .SIZE_J_IN         (SIZE_J_IN),
    .lane_valid        (lane_valid),
    .lane_result       (lane_result),
    .DATA_OUT          (DATA_OUT),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .READY             (READY),
    .matrix_done       (matrix_done)
  );

endmodule

// File: source/matrix_modular_pkg.sv
//////////////////////////////////////////////////
// Matrix modular adder shared definitions
// Widths, lane count, operation and FSM encodings
//////////////////////////////////////////////////

package matrix_modular_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Operands, modulus and result
  localparam int DATA_SIZE = 16;

  // Row and column sizes and counters
  localparam int INDEX_SIZE = 8;

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  // Parallel modular lanes, power of two from 2 up
  localparam int LANES = 4;

  // Round robin pointer width
  localparam int LANE_SEL_SIZE = $clog2(LANES);

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Element operation
  typedef enum logic [0:0] {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } operation_t;

  // Feeder FSM, idle until START then loading operands
  typedef enum logic [0:0] {
    FEEDER_IDLE = 1'b0,
    FEEDER_LOAD = 1'b1
  } feeder_state_t;

endpackage

// File: source/matrix_result_collector.sv
//////////////////////////////////////////////////
// Matrix result collector
// In-order lane drain, row/column strobes, READY
//////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_result_collector (
  input  logic                                     CLK,
  input  logic                                     RST,
  input  logic                                     START,
  input  logic [matrix_modular_pkg::INDEX_SIZE-1:0] SIZE_I_IN,
  input  logic [matrix_modular_pkg::INDEX_SIZE-1:0] SIZE_J_IN,
  input  logic [matrix_modular_pkg::LANES-1:0]      lane_valid,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0]  lane_result [matrix_modular_pkg::LANES],
  output logic [matrix_modular_pkg::DATA_SIZE-1:0]  DATA_OUT,
  output logic                                      DATA_OUT_J_ENABLE,
  output logic                                      DATA_OUT_I_ENABLE,
  output logic                                      READY,
  output logic                                      matrix_done
);

  // Matrix in progress
  logic busy;

  // Latched sizes
  logic [matrix_modular_pkg::INDEX_SIZE-1:0] size_i;
  logic [matrix_modular_pkg::INDEX_SIZE-1:0] size_j;

  // Position of the next element out
  logic [matrix_modular_pkg::INDEX_SIZE-1:0] row;
  logic [matrix_modular_pkg::INDEX_SIZE-1:0] col;

  // Next lane in issue order
  logic [matrix_modular_pkg::LANE_SEL_SIZE-1:0] lane_ptr;

  logic start_accept;
  logic take;
  logic last_col;
  logic last_row;

  // Idle only once the done pulse is gone, same cycle the feeder goes idle
  assign start_accept = START && !busy && !READY;
  assign take         = busy && lane_valid[lane_ptr];
  assign last_col     = (col == size_j - 1'b1);
  assign last_row     = (row == size_i - 1'b1);

  // Feeder release rides on READY
  assign matrix_done = READY;

  //////////////////////////////////////////////////
  // Counters and strobes
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy              <= 1'b0;
      row               <= '0;
      col               <= '0;
      lane_ptr          <= '0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      READY             <= 1'b0;
    end else begin
      // Pulses by default
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      READY             <= 1'b0;

      if (start_accept) begin
        busy     <= 1'b1;
        row      <= '0;
        col      <= '0;
        lane_ptr <= '0;
      end else if (take) begin
        DATA_OUT_J_ENABLE <= 1'b1;
        lane_ptr          <= lane_ptr + 1'b1;
        if (last_col) begin
          col <= '0;
          if (last_row) begin
            // Final element
            READY <= 1'b1;
            busy  <= 1'b0;
          end else begin
            // Row end
            DATA_OUT_I_ENABLE <= 1'b1;
            row               <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_accept) begin
      size_i <= SIZE_I_IN;
      size_j <= SIZE_J_IN;
    end
    if (take) begin
      DATA_OUT <= lane_result[lane_ptr];
    end
  end

endmodule

// File: source/modular_add_lane.sv
//////////////////////////////////////////////////
// Modular add lane
// Two-stage scalar A +/- B mod MODULO
//////////////////////////////////////////////////

`timescale 1ns/10ps

module modular_add_lane (
  input  logic                                     CLK,
  input  logic                                     RST,
  input  logic                                     start,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0] a,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0] b,
  input  matrix_modular_pkg::operation_t           op,
  input  logic [matrix_modular_pkg::DATA_SIZE-1:0] modulo,
  output logic                                     valid,
  output logic [matrix_modular_pkg::DATA_SIZE-1:0] result
);

  // Stage one, raw value with carry or borrow on top
  logic [matrix_modular_pkg::DATA_SIZE:0]   raw_s1;
  matrix_modular_pkg::operation_t           op_s1;
  logic [matrix_modular_pkg::DATA_SIZE-1:0] modulo_s1;
  logic                                     valid_s1;

  // Stage two input
  logic [matrix_modular_pkg::DATA_SIZE-1:0] corrected;

  // Valid pipe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_s1 <= 1'b0;
      valid    <= 1'b0;
    end else begin
      valid_s1 <= start;
      valid    <= valid_s1;
    end
  end

  // Single correction step, operands already below modulus
  always_comb begin
    if (op_s1 == matrix_modular_pkg::OP_ADD) begin
      if (raw_s1 >= {1'b0, modulo_s1}) begin
        corrected = raw_s1[matrix_modular_pkg::DATA_SIZE-1:0] - modulo_s1;
      end else begin
        corrected = raw_s1[matrix_modular_pkg::DATA_SIZE-1:0];
      end
    end else begin
      // Borrow means A was below B
      if (raw_s1[matrix_modular_pkg::DATA_SIZE]) begin
        corrected = raw_s1[matrix_modular_pkg::DATA_SIZE-1:0] + modulo_s1;
      end else begin
        corrected = raw_s1[matrix_modular_pkg::DATA_SIZE-1:0];
      end
    end
  end

  // Data follows its valid bit
  always_ff @(posedge CLK) begin
    if (start) begin
      if (op == matrix_modular_pkg::OP_ADD) begin
        raw_s1 <= {1'b0, a} + {1'b0, b};
      end else begin
        raw_s1 <= {1'b0, a} - {1'b0, b};
      end
      op_s1     <= op;
      modulo_s1 <= modulo;
    end
    if (valid_s1) begin
      result <= corrected;
    end
  end

endmodule

// File: test/matrix_modular_adder_properties.sv
//////////////////////////////////////////////////
// Matrix modular adder properties
// Reset, latency and strobe rules of the top level
//////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_modular_adder_properties (
  input logic                                 CLK,
  input logic                                 RST,
  input logic                                 DATA_OUT_J_ENABLE,
  input logic                                 DATA_OUT_I_ENABLE,
  input logic                                 READY,
  input logic [matrix_modular_pkg::LANES-1:0] lane_start,
  input logic [matrix_modular_pkg::LANES-1:0] lane_valid,
  input logic                                 matrix_done,
  input matrix_modular_pkg::feeder_state_t    feeder_state,
  input logic                                 pair_ready
);

  // Failures seen so far
  int fail_count = 0;

  // Nothing moving anywhere
  logic quiet;

  assign quiet = !DATA_OUT_J_ENABLE && !DATA_OUT_I_ENABLE && !READY &&
                 (lane_start == '0) && (lane_valid == '0) && !matrix_done &&
                 (feeder_state == matrix_modular_pkg::FEEDER_IDLE);

  // In reset and on the first edge after it
  quiet_after_reset: assert property (@(posedge CLK) (RST || $past(RST)) |-> quiet)
    else begin
      fail_count++;
      $error("outputs or lanes active in or right after reset");
    end

  // Pair complete one cycle after capture, so output is 4 cycles behind
  result_latency: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_J_ENABLE == $past(pair_ready, 4))
    else begin
      fail_count++;
      $error("DATA_OUT_J_ENABLE not 4 cycles after the pair was captured");
    end

  // READY only rides on the final element
  ready_with_element: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_J_ENABLE)
    else begin
      fail_count++;
      $error("READY without DATA_OUT_J_ENABLE");
    end

  // Row end only rides on an element
  row_end_with_element: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE)
    else begin
      fail_count++;
      $error("DATA_OUT_I_ENABLE without DATA_OUT_J_ENABLE");
    end

endmodule

// File: test/matrix_modular_adder_tb.sv
//////////////////////////////////////////////////
// Matrix modular adder testbench
// Random matrices against a modular reference model
//////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_modular_adder_tb;

  typedef logic [matrix_modular_pkg::DATA_SIZE-1:0]  data_t;
  typedef logic [matrix_modular_pkg::INDEX_SIZE-1:0] index_t;

  // Matrix shape, three matrices in the run
  localparam int ROWS            = 3;
  localparam int COLS            = 5;
  localparam int ELEMENTS        = 3 * ROWS * COLS;
  localparam int WATCHDOG_CYCLES = ELEMENTS * 20 + 100;
  localparam int READY_CYCLES    = ROWS * COLS * 8 + 20;

  logic                           CLK;
  logic                           RST;
  logic                           START;
  matrix_modular_pkg::operation_t OPERATION;
  data_t                          MODULO_IN;
  index_t                         SIZE_I_IN;
  index_t                         SIZE_J_IN;
  data_t                          DATA_A_IN;
  logic                           DATA_A_IN_ENABLE;
  data_t                          DATA_B_IN;
  logic                           DATA_B_IN_ENABLE;
  data_t                          DATA_OUT;
  logic                           DATA_OUT_J_ENABLE;
  logic                           DATA_OUT_I_ENABLE;
  logic                           READY;

  // Expected results in issue order
  data_t exp_value[$];
  int    exp_cycle[$];
  bit    exp_row_end[$];
  bit    exp_last[$];
  string exp_test[$];

  int cycle_count     = 0;
  int value_errors    = 0;
  int latency_errors  = 0;
  int strobe_errors   = 0;
  int protocol_errors = 0;

  tb_clock_gen u_clock (
    .CLK (CLK),
    .RST (RST)
  );

  matrix_modular_adder UUT (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .OPERATION         (OPERATION),
    .MODULO_IN         (MODULO_IN),
    .SIZE_I_IN         (SIZE_I_IN),
    .SIZE_J_IN         (SIZE_J_IN),
    .DATA_A_IN         (DATA_A_IN),
    .DATA_A_IN_ENABLE  (DATA_A_IN_ENABLE),
    .DATA_B_IN         (DATA_B_IN),
    .DATA_B_IN_ENABLE  (DATA_B_IN_ENABLE),
    .DATA_OUT          (DATA_OUT),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .READY             (READY)
  );

  bind matrix_modular_adder matrix_modular_adder_properties u_props (
    .CLK               (CLK),
    .RST               (RST),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .READY             (READY),
    .lane_start        (lane_start),
    .lane_valid        (lane_valid),
    .matrix_done       (matrix_done),
    .feeder_state      (u_feeder.state),
    .pair_ready        (u_feeder.pair_ready)
  );

  // Edge count, read after the edge settles
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  // One reduction step, operands below the modulus
  function automatic int expected_result(matrix_modular_pkg::operation_t op, int a, int b,
                                         int m);
    int r;
    if (op == matrix_modular_pkg::OP_ADD) begin
      r = a + b;
      if (r >= m)
        r = r - m;
    end else begin
      r = a - b;
      if (r < 0)
        r = r + m;
    end
    return r;
  endfunction

  // Pair completes in this cycle, captured next edge, out 4 cycles later
  task automatic expect_result(string test, data_t value, bit row_end, bit last);
    exp_value.push_back(value);
    exp_cycle.push_back(cycle_count + 5);
    exp_row_end.push_back(row_end);
    exp_last.push_back(last);
    exp_test.push_back(test);
  endtask

  task automatic check_output();
    data_t value;
    int    due;
    bit    row_end;
    bit    last;
    string test;
    if (exp_value.size() == 0) begin
      protocol_errors++;
      $display("Output strobe at cycle %0d with no element pending", cycle_count);
      return;
    end
    value   = exp_value.pop_front();
    due     = exp_cycle.pop_front();
    row_end = exp_row_end.pop_front();
    last    = exp_last.pop_front();
    test    = exp_test.pop_front();
    assert (DATA_OUT == value) else begin
      value_errors++;
      $display("FAILED %s value: expected %0d, actual %0d", test, value, DATA_OUT);
    end
    assert (cycle_count == due) else begin
      latency_errors++;
      $display("FAILED %s latency: expected cycle %0d, actual cycle %0d", test, due,
               cycle_count);
    end
    assert (DATA_OUT_I_ENABLE == row_end) else begin
      strobe_errors++;
      $display("FAILED %s row strobe: expected %0d, actual %0d", test, row_end,
               DATA_OUT_I_ENABLE);
    end
    assert (READY == last) else begin
      strobe_errors++;
      $display("FAILED %s READY: expected %0d, actual %0d", test, last, READY);
    end
  endtask

  // Sampled away from the edges
  always @(negedge CLK) begin
    if (!RST && DATA_OUT_J_ENABLE) begin
      check_output();
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_for_ready(string test);
    int waited;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!READY && waited < READY_CYCLES);
    if (!READY) begin
      protocol_errors++;
      $display("READY never came for %s", test);
    end
  endtask

  task automatic run_matrix(string test, matrix_modular_pkg::operation_t op, int modulus,
                            bit stray_start);
    int a;
    int b;
    int swap;
    int mode;
    int gap;
    bit row_end;
    bit last;
    // Latch operation, modulus and sizes
    next_cycle();
    START     = 1'b1;
    OPERATION = op;
    MODULO_IN = data_t'(modulus);
    SIZE_I_IN = index_t'(ROWS);
    SIZE_J_IN = index_t'(COLS);
    next_cycle();
    START = 1'b0;
    for (int n = 0; n < ROWS * COLS; n++) begin
      // START mid-matrix with other settings, must be ignored
      if (stray_start && n == 7) begin
        START     = 1'b1;
        OPERATION = (op == matrix_modular_pkg::OP_ADD) ? matrix_modular_pkg::OP_SUB
                                                        : matrix_modular_pkg::OP_ADD;
        MODULO_IN = data_t'(modulus - 2);
        SIZE_I_IN = index_t'(1);
        SIZE_J_IN = index_t'(1);
        next_cycle();
        START = 1'b0;
      end
      a = int'($urandom % modulus);
      b = int'($urandom % modulus);
      // Every other subtract goes negative
      if (op == matrix_modular_pkg::OP_SUB && n % 2 == 0 && a > b) begin
        swap = a;
        a    = b;
        b    = swap;
      end
      row_end = (n % COLS == COLS - 1) && (n != ROWS * COLS - 1);
      last    = (n == ROWS * COLS - 1);
      mode    = int'($urandom % 3);
      gap     = int'($urandom % 3);
      DATA_A_IN = data_t'(a);
      DATA_B_IN = data_t'(b);
      if (mode == 1) begin
        // A first, then B after a gap
        DATA_A_IN_ENABLE = 1'b1;
        next_cycle();
        DATA_A_IN_ENABLE = 1'b0;
        repeat (gap) next_cycle();
        DATA_B_IN_ENABLE = 1'b1;
      end else if (mode == 2) begin
        // B first
        DATA_B_IN_ENABLE = 1'b1;
        next_cycle();
        DATA_B_IN_ENABLE = 1'b0;
        repeat (gap) next_cycle();
        DATA_A_IN_ENABLE = 1'b1;
      end else begin
        DATA_A_IN_ENABLE = 1'b1;
        DATA_B_IN_ENABLE = 1'b1;
      end
      expect_result(test, data_t'(expected_result(op, a, b, modulus)), row_end, last);
      next_cycle();
      DATA_A_IN_ENABLE = 1'b0;
      DATA_B_IN_ENABLE = 1'b0;
    end
    wait_for_ready(test);
  endtask

  task automatic print_counts();
    $display("Errors: value %0d, latency %0d, strobe %0d, protocol %0d, assertion %0d",
             value_errors, latency_errors, strobe_errors, protocol_errors,
             UUT.u_props.fail_count);
  endtask

  task automatic finish_run();
    int total;
    if (exp_value.size() != 0) begin
      protocol_errors += exp_value.size();
      $display("%0d expected results never appeared", exp_value.size());
    end
    print_counts();
    total = value_errors + latency_errors + strobe_errors + protocol_errors +
            UUT.u_props.fail_count;
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  initial begin
    int modulus;
    void'($urandom(83));
    START            = 1'b0;
    OPERATION        = matrix_modular_pkg::OP_ADD;
    MODULO_IN        = '0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_A_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN        = '0;
    DATA_B_IN_ENABLE = 1'b0;
    @(negedge RST);
    // Operands while idle, never paired
    next_cycle();
    DATA_A_IN        = data_t'(16'h1234);
    DATA_B_IN        = data_t'(16'h0042);
    DATA_A_IN_ENABLE = 1'b1;
    DATA_B_IN_ENABLE = 1'b1;
    next_cycle();
    DATA_A_IN_ENABLE = 1'b0;
    next_cycle();
    DATA_B_IN_ENABLE = 1'b0;
    // Random odd moduli
    modulus = int'($urandom % 30000) * 2 + 1001;
    run_matrix("add_random", matrix_modular_pkg::OP_ADD, modulus, 1'b0);
    modulus = int'($urandom % 30000) * 2 + 1001;
    run_matrix("sub_back_to_back", matrix_modular_pkg::OP_SUB, modulus, 1'b1);
    // Sums carry past 16 bits
    run_matrix("add_wide_modulus", matrix_modular_pkg::OP_ADD, 65521, 1'b0);
    repeat (10) next_cycle();
    finish_run();
  end

  // 20 cycles per element plus margin
  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("Timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
//////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns clock, reset held for 10 cycles
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  localparam int RESET_CYCLES = 10;

  // 125 MHz
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RST = 1'b0;
  end

endmodule
